/* design/htree_defs.svh */
`ifndef HTREE_DEFS_SVH
`define HTREE_DEFS_SVH

// Tree builder sizes
`define HT_SYMS     16                 // Leaf symbols in one table
`define HT_SUMS     (`HT_SYMS - 1)     // At most one internal node per merge
`define HT_COUNT_W  20                 // Frequency and sum count width
`define HT_IDX_W    4                  // Leaf or sum slot index
`define HT_ID_W     6                  // {null, is_sum, slot}

// Null id, both top bits set
`define HT_NULL_ID  6'b110000

// Node record {left id, right id, count}, also the Wishbone data word
`define HT_REC_W    (2 * `HT_ID_W + `HT_COUNT_W)

// One picker candidate {valid, id, count}
`define HT_CAND_W   (1 + `HT_ID_W + `HT_COUNT_W)

`endif

/* design/htree_pkg.sv */
`default_nettype none

`include "htree_defs.svh"

package htree_pkg;

  typedef logic [`HT_COUNT_W-1:0]  count_t;    // Frequency or sum count
  typedef logic [`HT_IDX_W-1:0]    idx_t;      // Slot index
  typedef logic [`HT_ID_W-1:0]     node_id_t;  // Bit 4 marks a sum node
  typedef logic [`HT_REC_W-1:0]    node_rec_t; // {left, right, count}
  typedef logic [`HT_CAND_W-1:0]   cand_t;     // {valid, id, count}
  typedef logic [2*`HT_CAND_W-1:0] pair_t;     // {least, next least}

  typedef enum logic [1:0] {
    IDLE,   // Waiting for start
    PICK,   // Choose the two least live nodes
    WRITE,  // Wishbone write of one record
    FIN     // Done pulse
  } merge_state_t;

  // True when x ranks strictly before y
  // Smaller count first, then smaller id, so a leaf beats a sum node on a tie
  function automatic logic rank_lt(input cand_t x, input cand_t y);
    logic [`HT_COUNT_W+`HT_ID_W-1:0] key_x;
    logic [`HT_COUNT_W+`HT_ID_W-1:0] key_y;
    key_x = {x[`HT_COUNT_W-1:0], x[`HT_CAND_W-2 -: `HT_ID_W]};
    key_y = {y[`HT_COUNT_W-1:0], y[`HT_CAND_W-2 -: `HT_ID_W]};
    return x[`HT_CAND_W-1] && (!y[`HT_CAND_W-1] || (key_x < key_y));
  endfunction

  // Two least of two sorted pairs
  function automatic pair_t merge_pair(input pair_t p, input pair_t q);
    cand_t p1;
    cand_t p2;
    cand_t q1;
    cand_t q2;
    p1 = p[2*`HT_CAND_W-1:`HT_CAND_W];
    p2 = p[`HT_CAND_W-1:0];
    q1 = q[2*`HT_CAND_W-1:`HT_CAND_W];
    q2 = q[`HT_CAND_W-1:0];
    if (rank_lt(q1, p1))
      return {q1, rank_lt(q2, p1) ? q2 : p1};  // q1 leads, runner up is q2 or p1
    else
      return {p1, rank_lt(q1, p2) ? q1 : p2};
  endfunction

  // Scan tree over one table, log2 levels of pair merges
  function automatic pair_t top_two(input logic [`HT_SYMS-1:0] live,
                                    input logic [`HT_SYMS*`HT_COUNT_W-1:0] cnts,
                                    input logic sum_side);
    pair_t lvl [`HT_SYMS];
    int    step;
    int    i;
    for (i = 0; i < `HT_SYMS; i++) begin
      lvl[i] = {live[i], 1'b0, sum_side, idx_t'(i), cnts[i*`HT_COUNT_W +: `HT_COUNT_W],
                1'b0, `HT_NULL_ID, {`HT_COUNT_W{1'b0}}};  // Leaf level, empty runner up
    end
    for (step = 1; step < `HT_SYMS; step = step * 2) begin
      for (i = 0; i < `HT_SYMS; i = i + 2 * step) begin
        lvl[i] = merge_pair(lvl[i], lvl[i+step]);
      end
    end
    return lvl[0];
  endfunction

endpackage

`default_nettype wire

/* design/leaf_picker.sv */
`default_nettype none
`timescale 1ns/1ns

`include "htree_defs.svh"

module leaf_picker
  import htree_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  // Table load, idle only
  input  logic     freq_we,
  input  idx_t     freq_sym,
  input  count_t   freq_count,
  // From the merger
  input  logic     clear,
  input  logic     take_leaf,
  input  idx_t     take_leaf_idx,
  // Two least live leaves
  output logic     a_valid,
  output node_id_t a_id,
  output count_t   a_count,
  output logic     b_valid,
  output node_id_t b_id,
  output count_t   b_count
);

  count_t                          freq [`HT_SYMS];  // Loaded counts
  logic [`HT_SYMS-1:0]             used;             // Consumed by a merge
  logic [`HT_SYMS-1:0]             live;
  logic [`HT_SYMS*`HT_COUNT_W-1:0] freq_flat;

  // Frequency table
  always_ff @(posedge clk) begin
    if (freq_we)
      freq[freq_sym] <= freq_count;
  end

  // Used flags, cleared at start of every build
  always_ff @(posedge clk or posedge rst_n) begin
    if (rst_n) begin
      used <= '0;
    end else if (clear) begin
      used <= '0;
    end else if (take_leaf) begin
      used[take_leaf_idx] <= 1'b1;  // Second take of a pair lands one cycle later
    end
  end

  // A zero count never enters the tree
  always_comb begin
    for (int i = 0; i < `HT_SYMS; i++) begin
      live[i]                              = !used[i] && (freq[i] != '0);
      freq_flat[i*`HT_COUNT_W +: `HT_COUNT_W] = freq[i];
    end
  end

  assign {a_valid, a_id, a_count, b_valid, b_id, b_count} = top_two(live, freq_flat, 1'b0);

  // The merger only consumes leaves this picker offered as live
  a_take_live: assert property (@(posedge clk) disable iff (rst_n)
    take_leaf |-> live[take_leaf_idx])
    else $error("take_leaf on dead leaf %0d", take_leaf_idx);

endmodule

`default_nettype wire

/* design/sum_picker.sv */
`default_nettype none
`timescale 1ns/1ns

`include "htree_defs.svh"

module sum_picker
  import htree_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  // From the merger
  input  logic     clear,
  input  logic     new_sum,        // Record acked, slot becomes live
  input  idx_t     new_sum_idx,
  input  count_t   new_sum_count,
  input  logic     take_sum,
  input  idx_t     take_sum_idx,
  // Two least live sum nodes
  output logic     a_valid,
  output node_id_t a_id,
  output count_t   a_count,
  output logic     b_valid,
  output node_id_t b_id,
  output count_t   b_count
);

  count_t                          sums [`HT_SUMS];  // Internal node counts
  logic [`HT_SUMS-1:0]             live;             // Written and not yet consumed
  logic [`HT_SYMS-1:0]             live_flat;        // Widened to the scan tree size
  logic [`HT_SYMS*`HT_COUNT_W-1:0] sums_flat;

  // Counts, written once per slot per build
  always_ff @(posedge clk) begin
    if (new_sum)
      sums[new_sum_idx] <= new_sum_count;
  end

  // Live flags
  always_ff @(posedge clk or posedge rst_n) begin
    if (rst_n) begin
      live <= '0;
    end else if (clear) begin
      live <= '0;
    end else begin
      if (new_sum)
        live[new_sum_idx] <= 1'b1;
      if (take_sum)
        live[take_sum_idx] <= 1'b0;  // Never the slot being created
    end
  end

  // Top slot of the scan tree stays empty
  always_comb begin
    live_flat = '0;
    sums_flat = '0;
    for (int i = 0; i < `HT_SUMS; i++) begin
      live_flat[i]                            = live[i];
      sums_flat[i*`HT_COUNT_W +: `HT_COUNT_W] = sums[i];
    end
  end

  assign {a_valid, a_id, a_count, b_valid, b_id, b_count} = top_two(live_flat, sums_flat, 1'b1);

  // Slots are handed out in order, so a live slot is never reused in one build
  a_new_free: assert property (@(posedge clk) disable iff (rst_n)
    new_sum |-> (new_sum_idx < `HT_SUMS) && !live[new_sum_idx])
    else $error("new_sum onto live slot %0d", new_sum_idx);

  // Consumed sum node was offered as live
  a_take_live: assert property (@(posedge clk) disable iff (rst_n)
    take_sum |-> live[take_sum_idx])
    else $error("take_sum on dead slot %0d", take_sum_idx);

endmodule

`default_nettype wire

/* design/node_merger.sv */
`default_nettype none
`timescale 1ns/1ns

`include "htree_defs.svh"

module node_merger
  import htree_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      start,
  // Leaf picker candidates
  input  logic      leaf_a_valid,
  input  node_id_t  leaf_a_id,
  input  count_t    leaf_a_count,
  input  logic      leaf_b_valid,
  input  node_id_t  leaf_b_id,
  input  count_t    leaf_b_count,
  // Sum picker candidates
  input  logic      sum_a_valid,
  input  node_id_t  sum_a_id,
  input  count_t    sum_a_count,
  input  logic      sum_b_valid,
  input  node_id_t  sum_b_id,
  input  count_t    sum_b_count,
  // Picker controls
  output logic      clear,
  output logic      take_leaf,
  output idx_t      take_leaf_idx,
  output logic      take_sum,
  output idx_t      take_sum_idx,
  output logic      new_sum,
  output idx_t      new_sum_idx,
  output count_t    new_sum_count,
  // Status
  output logic      busy,
  output logic      done,
  output node_id_t  root_id,
  // Wishbone classic master
  output logic      wb_cyc,
  output logic      wb_stb,
  output logic      wb_we,
  output idx_t      wb_adr,
  output node_rec_t wb_dat_w,
  input  logic      wb_ack
);

  merge_state_t state;
  idx_t         next_slot;   // Record address and new sum slot
  logic         pend_take;   // Second take to the same picker still owed
  node_rec_t    rec;         // Record under write
  logic         has_second;  // False for the single symbol record

  pair_t        best;
  cand_t        best1;
  cand_t        best2;
  logic         best1_valid;
  logic         best2_valid;
  node_id_t     best1_id;
  node_id_t     best2_id;
  count_t       pick_sum;
  logic         go_write;

  node_id_t     first_id;
  node_id_t     second_id;
  logic         first_is_sum;
  logic         second_is_sum;
  logic         ack_now;

  // Global two least from four candidates
  assign best = merge_pair({leaf_a_valid, leaf_a_id, leaf_a_count,
                            leaf_b_valid, leaf_b_id, leaf_b_count},
                           {sum_a_valid, sum_a_id, sum_a_count,
                            sum_b_valid, sum_b_id, sum_b_count});
  assign best1       = best[2*`HT_CAND_W-1:`HT_CAND_W];
  assign best2       = best[`HT_CAND_W-1:0];
  assign best1_valid = best1[`HT_CAND_W-1];
  assign best2_valid = best2[`HT_CAND_W-1];
  assign best1_id    = best1[`HT_CAND_W-2 -: `HT_ID_W];
  assign best2_id    = best2[`HT_CAND_W-2 -: `HT_ID_W];
  assign pick_sum    = best2_valid ? best1[`HT_COUNT_W-1:0] + best2[`HT_COUNT_W-1:0]
                                   : best1[`HT_COUNT_W-1:0];

  // Two live nodes, or a lone leaf before any record
  assign go_write = best1_valid && (best2_valid || (next_slot == '0));

  // FSM
  always_ff @(posedge clk or posedge rst_n) begin
    if (rst_n) begin
      state     <= IDLE;
      next_slot <= '0;
      pend_take <= 1'b0;
      root_id   <= `HT_NULL_ID;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            state     <= PICK;
            next_slot <= '0;
          end
        end
        PICK: begin
          if (pend_take) begin
            pend_take <= 1'b0;  // Hold one cycle while the second take lands
          end else if (go_write) begin
            state <= WRITE;
          end else begin
            state   <= FIN;
            root_id <= best1_valid ? best1_id : `HT_NULL_ID;  // Null for an empty table
          end
        end
        WRITE: begin
          if (wb_ack) begin
            state     <= PICK;
            next_slot <= next_slot + 1'b1;
            pend_take <= has_second && (first_is_sum == second_is_sum);
          end
        end
        FIN:     state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Record latched in PICK, steady through WRITE
  always_ff @(posedge clk) begin
    if ((state == PICK) && !pend_take) begin
      rec        <= {best1_id, best2_valid ? best2_id : `HT_NULL_ID, pick_sum};
      has_second <= best2_valid;
    end
  end

  assign first_id      = rec[`HT_REC_W-1 -: `HT_ID_W];
  assign second_id     = rec[`HT_REC_W-`HT_ID_W-1 -: `HT_ID_W];
  assign first_is_sum  = first_id[`HT_IDX_W];
  assign second_is_sum = second_id[`HT_IDX_W];
  assign ack_now       = (state == WRITE) && wb_ack;

  // Takes on ack, second one a cycle later when both sit in one picker
  assign take_leaf = (ack_now && (!first_is_sum || (has_second && !second_is_sum))) ||
                     (pend_take && !second_is_sum);
  assign take_sum  = (ack_now && (first_is_sum || (has_second && second_is_sum))) ||
                     (pend_take && second_is_sum);
  assign take_leaf_idx = (ack_now && !first_is_sum) ? first_id[`HT_IDX_W-1:0]
                                                    : second_id[`HT_IDX_W-1:0];
  assign take_sum_idx  = (ack_now && first_is_sum) ? first_id[`HT_IDX_W-1:0]
                                                   : second_id[`HT_IDX_W-1:0];

  // New internal node becomes live with the ack
  assign new_sum       = ack_now;
  assign new_sum_idx   = next_slot;
  assign new_sum_count = rec[`HT_COUNT_W-1:0];

  assign clear = (state == IDLE) && start;  // Fresh tables for each build
  assign busy  = (state != IDLE);
  assign done  = (state == FIN);

  // Bus strobes follow WRITE, so they drop the cycle after ack
  assign wb_cyc   = (state == WRITE);
  assign wb_stb   = (state == WRITE);
  assign wb_we    = (state == WRITE);
  assign wb_adr   = next_slot;
  assign wb_dat_w = rec;

  // Waiting strobe keeps cycle, address and data until the slave acks
  a_wb_hold: assert property (@(posedge clk) disable iff (rst_n)
    wb_stb && !wb_ack |=> wb_stb && wb_cyc && $stable(wb_adr) && $stable(wb_dat_w))
    else $error("Wishbone request changed before ack");

endmodule

`default_nettype wire

/* design/htree_builder.sv */
`default_nettype none
`timescale 1ns/1ns

`include "htree_defs.svh"

module htree_builder
  import htree_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  // Frequency load
  input  logic      freq_we,
  input  idx_t      freq_sym,
  input  count_t    freq_count,
  // Control and status
  input  logic      start,
  output logic      busy,
  output logic      done,
  output node_id_t  root_id,
  // Node memory, Wishbone classic
  output logic      wb_cyc,
  output logic      wb_stb,
  output logic      wb_we,
  output idx_t      wb_adr,
  output node_rec_t wb_dat_w,
  input  logic      wb_ack
);

  // Leaf candidates
  logic     leaf_a_valid;
  node_id_t leaf_a_id;
  count_t   leaf_a_count;
  logic     leaf_b_valid;
  node_id_t leaf_b_id;
  count_t   leaf_b_count;
  // Sum candidates
  logic     sum_a_valid;
  node_id_t sum_a_id;
  count_t   sum_a_count;
  logic     sum_b_valid;
  node_id_t sum_b_id;
  count_t   sum_b_count;
  // Merger to pickers
  logic     clear;
  logic     take_leaf;
  idx_t     take_leaf_idx;
  logic     take_sum;
  idx_t     take_sum_idx;
  logic     new_sum;
  idx_t     new_sum_idx;
  count_t   new_sum_count;

  leaf_picker leaf_picker_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .freq_we       (freq_we),
    .freq_sym      (freq_sym),
    .freq_count    (freq_count),
    .clear         (clear),
    .take_leaf     (take_leaf),
    .take_leaf_idx (take_leaf_idx),
    .a_valid       (leaf_a_valid),
    .a_id          (leaf_a_id),
    .a_count       (leaf_a_count),
    .b_valid       (leaf_b_valid),
    .b_id          (leaf_b_id),
    .b_count       (leaf_b_count)
  );

  sum_picker sum_picker_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .clear         (clear),
    .new_sum       (new_sum),
    .new_sum_idx   (new_sum_idx),
    .new_sum_count (new_sum_count),
    .take_sum      (take_sum),
    .take_sum_idx  (take_sum_idx),
    .a_valid       (sum_a_valid),
    .a_id          (sum_a_id),
    .a_count       (sum_a_count),
    .b_valid       (sum_b_valid),
    .b_id          (sum_b_id),
    .b_count       (sum_b_count)
  );

  node_merger node_merger_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .start         (start),
    .leaf_a_valid  (leaf_a_valid),
    .leaf_a_id     (leaf_a_id),
    .leaf_a_count  (leaf_a_count),
    .leaf_b_valid  (leaf_b_valid),
    .leaf_b_id     (leaf_b_id),
    .leaf_b_count  (leaf_b_count),
    .sum_a_valid   (sum_a_valid),
    .sum_a_id      (sum_a_id),
    .sum_a_count   (sum_a_count),
    .sum_b_valid   (sum_b_valid),
    .sum_b_id      (sum_b_id),
    .sum_b_count   (sum_b_count),
    .clear         (clear),
    .take_leaf     (take_leaf),
    .take_leaf_idx (take_leaf_idx),
    .take_sum      (take_sum),
    .take_sum_idx  (take_sum_idx),
    .new_sum       (new_sum),
    .new_sum_idx   (new_sum_idx),
    .new_sum_count (new_sum_count),
    .busy          (busy),
    .done          (done),
    .root_id       (root_id),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_we         (wb_we),
    .wb_adr        (wb_adr),
    .wb_dat_w      (wb_dat_w),
    .wb_ack        (wb_ack)
  );

endmodule

`default_nettype wire

/* verification/tb_node_mem.sv */
`default_nettype none
`timescale 1ns/1ns

`include "htree_defs.svh"

module tb_node_mem
  import htree_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  // Wishbone classic slave
  input  logic      wb_cyc,
  input  logic      wb_stb,
  input  logic      wb_we,
  input  idx_t      wb_adr,
  input  node_rec_t wb_dat_w,
  output logic      wb_ack
);

  node_rec_t   mem [`HT_SYMS];  // Node records by slot
  logic [31:0] lfsr;            // Wait state source
  logic [31:0] lfsr_1;
  logic [31:0] lfsr_2;
  logic [1:0]  draw;            // 0 to 3 wait cycles
  logic [1:0]  wait_left;
  logic        armed;           // Request seen, wait count loaded

  // Galois LFSR, one step per bit
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  assign lfsr_1 = lfsr_next(lfsr);
  assign lfsr_2 = lfsr_next(lfsr_1);
  assign draw   = {lfsr[0], lfsr_1[0]};  // Two bits, two steps

  always_ff @(posedge clk or posedge rst_n) begin
    if (rst_n) begin
      wb_ack    <= 1'b0;
      armed     <= 1'b0;
      wait_left <= '0;
      lfsr      <= 32'h152c;
    end else if (wb_ack) begin
      wb_ack <= 1'b0;  // Single cycle ack
      armed  <= 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (!armed) begin
        armed     <= 1'b1;
        lfsr      <= lfsr_2;
        wait_left <= draw;
        wb_ack    <= (draw == 2'd0);  // No wait at all
      end else begin
        wait_left <= wait_left - 1'b1;
        wb_ack    <= (wait_left == 2'd1);
      end
    end
  end

  // Record lands with the ack
  always_ff @(posedge clk) begin
    if (wb_cyc && wb_stb && wb_we && wb_ack)
      mem[wb_adr] <= wb_dat_w;
  end

endmodule

`default_nettype wire

/* verification/htree_tb.sv */
`default_nettype none
`timescale 1ns/1ns

`include "htree_defs.svh"

module htree_tb
  import htree_pkg::*;
;

  localparam int NUM_TABLES      = 6;   // Kinds 0 to 4, then kind 0 again
  localparam int LOAD_CYCLES     = 24;  // Sixteen loads plus start
  localparam int WORST_WRITE     = 8;   // PICK, second take, WRITE with 3 waits, FIN
  localparam int WATCHDOG_CYCLES = 8 + NUM_TABLES * (LOAD_CYCLES + `HT_SYMS * WORST_WRITE);
  localparam int KEY_W           = `HT_COUNT_W + `HT_ID_W;  // {count, id}

  logic      clk;
  logic      rst_n;
  logic      freq_we;
  idx_t      freq_sym;
  count_t    freq_count;
  logic      start;
  logic      busy;
  logic      done;
  node_id_t  root_id;
  logic      wb_cyc;
  logic      wb_stb;
  logic      wb_we;
  idx_t      wb_adr;
  node_rec_t wb_dat_w;
  logic      wb_ack;

  // Reference model
  count_t              leaf_cnt [`HT_SYMS];
  logic [`HT_SYMS-1:0] leaf_used;
  count_t              sum_cnt [`HT_SUMS];
  logic [`HT_SUMS-1:0] sum_live;
  int                  rec_cnt;     // Records acked this build
  logic [KEY_W-1:0]    first_key;
  logic [KEY_W-1:0]    second_key;
  logic                first_ok;
  logic                second_ok;
  node_id_t            exp_left;
  node_id_t            exp_right;
  count_t              exp_count;
  count_t              child_sum;   // From the ids the DUT wrote
  count_t              total;
  count_t              last_cnt;
  int                  nz;
  int                  exp_recs;
  node_id_t            exp_root;
  logic [31:0]         lfsr_state;

  htree_builder htree_builder_inst (
    .clk(clk), .rst_n(rst_n), .freq_we(freq_we), .freq_sym(freq_sym),
    .freq_count(freq_count), .start(start), .busy(busy), .done(done), .root_id(root_id),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_ack(wb_ack)
  );

  tb_node_mem tb_node_mem_inst (
    .clk(clk), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_ack(wb_ack)
  );

  task automatic stop_run();
    $display("test failed");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] want);
    $display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, want);
    stop_run();
  endtask

  task automatic check_failed(input string what);
    $display("Error at %0t ns: %s", $time, what);
    stop_run();
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int k = 0; k < n; k++) begin
      val        = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic count_t count_of(input node_id_t id);
    if (id[`HT_ID_W-1])
      return '0;                           // Null child
    else if (id[`HT_IDX_W])
      return tb_node_mem_inst.mem[id[`HT_IDX_W-1:0]][`HT_COUNT_W-1:0];  // Earlier record
    else
      return leaf_cnt[id[`HT_IDX_W-1:0]];  // Loaded leaf
  endfunction

  // Linear scan of all live nodes, keyed by count then id
  always_comb begin
    logic [KEY_W-1:0] key;
    logic             live;
    first_ok   = 1'b0;
    second_ok  = 1'b0;
    first_key  = '0;
    second_key = '0;
    for (int n = 0; n < `HT_SYMS + `HT_SUMS; n++) begin
      if (n < `HT_SYMS) begin
        live = !leaf_used[n] && (leaf_cnt[n] != '0);
        key  = {leaf_cnt[n], node_id_t'(n)};
      end else begin
        live = sum_live[n-`HT_SYMS];
        key  = {sum_cnt[n-`HT_SYMS], node_id_t'(n)};  // Id 16 up is sum slot 0 up
      end
      if (live && (!first_ok || key < first_key)) begin
        second_key = first_key;
        second_ok  = first_ok;
        first_key  = key;
        first_ok   = 1'b1;
      end else if (live && (!second_ok || key < second_key)) begin
        second_key = key;
        second_ok  = 1'b1;
      end
    end
    exp_left  = first_key[`HT_ID_W-1:0];
    exp_right = second_ok ? second_key[`HT_ID_W-1:0] : `HT_NULL_ID;
    exp_count = first_key[KEY_W-1:`HT_ID_W] + (second_ok ? second_key[KEY_W-1:`HT_ID_W] : '0);
  end

  always_comb begin
    nz    = 0;
    total = '0;
    for (int i = 0; i < `HT_SYMS; i++) begin
      if (leaf_cnt[i] != '0)
        nz = nz + 1;
      total = total + leaf_cnt[i];
    end
    exp_recs  = (nz > 1) ? nz - 1 : nz;  // Lone symbol still gets a record
    exp_root  = (nz == 0) ? `HT_NULL_ID : {2'b01, idx_t'(rec_cnt - 1)};
    // Root record as the node memory holds it
    last_cnt  = (rec_cnt > 0) ? tb_node_mem_inst.mem[rec_cnt-1][`HT_COUNT_W-1:0] : '0;
    child_sum = count_of(wb_dat_w[`HT_REC_W-1 -: `HT_ID_W]) +
                count_of(wb_dat_w[`HT_REC_W-`HT_ID_W-1 -: `HT_ID_W]);
  end

  always_ff @(posedge clk) begin
    if (freq_we)
      leaf_cnt[freq_sym] <= freq_count;
  end

  // Model follows each acked record with the predicted ids
  always_ff @(posedge clk or posedge rst_n) begin
    if (rst_n) begin
      leaf_used <= '0;
      sum_live  <= '0;
      rec_cnt   <= 0;
    end else if (start) begin
      leaf_used <= '0;
      sum_live  <= '0;
      rec_cnt   <= 0;
    end else if (wb_stb && wb_ack) begin
      if (exp_left[`HT_IDX_W])
        sum_live[exp_left[`HT_IDX_W-1:0]] <= 1'b0;
      else
        leaf_used[exp_left[`HT_IDX_W-1:0]] <= 1'b1;
      if (second_ok && exp_right[`HT_IDX_W])
        sum_live[exp_right[`HT_IDX_W-1:0]] <= 1'b0;
      else if (second_ok)
        leaf_used[exp_right[`HT_IDX_W-1:0]] <= 1'b1;
      sum_live[rec_cnt] <= 1'b1;  // New slot is never one just taken
      sum_cnt[rec_cnt]  <= exp_count;
      rec_cnt           <= rec_cnt + 1;
    end
  end

  // Record contents
  a_rec_count: assert property (@(posedge clk) disable iff (rst_n)
    wb_stb && wb_ack |-> wb_dat_w[`HT_COUNT_W-1:0] == child_sum)
    else mismatch("record count", $sampled(wb_dat_w[`HT_COUNT_W-1:0]), $sampled(child_sum));
  a_rec_left: assert property (@(posedge clk) disable iff (rst_n)
    wb_stb && wb_ack |-> wb_dat_w[`HT_REC_W-1 -: `HT_ID_W] == exp_left)
    else mismatch("record left id", $sampled(wb_dat_w[`HT_REC_W-1 -: `HT_ID_W]),
                  $sampled(exp_left));
  a_rec_right: assert property (@(posedge clk) disable iff (rst_n)
    wb_stb && wb_ack |-> wb_dat_w[`HT_REC_W-`HT_ID_W-1 -: `HT_ID_W] == exp_right)
    else mismatch("record right id", $sampled(wb_dat_w[`HT_REC_W-`HT_ID_W-1 -: `HT_ID_W]),
                  $sampled(exp_right));
  a_rec_adr: assert property (@(posedge clk) disable iff (rst_n)
    wb_stb && wb_ack |-> wb_adr == idx_t'(rec_cnt))
    else mismatch("wb_adr", $sampled(wb_adr), $sampled(rec_cnt));
  a_rec_limit: assert property (@(posedge clk) disable iff (rst_n)
    wb_stb |-> rec_cnt < exp_recs)
    else check_failed("a record was written after the tree was complete");

  // End of a build
  a_done_recs: assert property (@(posedge clk) disable iff (rst_n)
    done |-> rec_cnt == exp_recs)
    else mismatch("record total", $sampled(rec_cnt), $sampled(exp_recs));
  a_done_root: assert property (@(posedge clk) disable iff (rst_n)
    done |-> root_id == exp_root)
    else mismatch("root_id", $sampled(root_id), $sampled(exp_root));
  a_done_total: assert property (@(posedge clk) disable iff (rst_n)
    done && (nz != 0) |-> last_cnt == total)
    else mismatch("root count", $sampled(last_cnt), $sampled(total));
  a_done_once: assert property (@(posedge clk) disable iff (rst_n) done |=> !done)
    else check_failed("done stayed high for more than one cycle");

  // Bus and status protocol
  a_stb_cyc: assert property (@(posedge clk) disable iff (rst_n) wb_stb |-> wb_cyc && wb_we)
    else check_failed("wb_stb without wb_cyc and wb_we");
  a_wb_hold: assert property (@(posedge clk) disable iff (rst_n)
    wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_dat_w))
    else check_failed("Wishbone request changed before ack");
  a_busy_start: assert property (@(posedge clk) disable iff (rst_n) start |=> busy)
    else check_failed("busy did not rise after start");
  a_busy_hold: assert property (@(posedge clk) disable iff (rst_n) busy && !done |=> busy)
    else check_failed("busy dropped before done");

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Kind 0 small counts, 1 lone symbol, 2 wide counts, 3 empty, 4 all sixteen live
  task automatic load_table(input int kind);
    logic [31:0] lone;
    logic [31:0] r;
    logic [31:0] c;
    draw_bits(4, lone);
    for (int s = 0; s < `HT_SYMS; s++) begin
      case (kind)
        0: draw_bits(3, c);  // Plenty of zeros and ties
        1: c = (s == lone) ? 32'd5 + s : 32'd0;
        2: begin
          draw_bits(2, r);
          draw_bits(16, c);
          if (r == 0)
            c = 0;
        end
        3: c = 0;
        default: begin
          draw_bits(4, c);
          c = c + 1;
        end
      endcase
      @(posedge clk);
      freq_we    <= 1'b1;
      freq_sym   <= idx_t'(s);
      freq_count <= count_t'(c);
    end
    @(posedge clk);
    freq_we <= 1'b0;
  endtask

  task automatic run_build();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    do
      @(negedge clk);  // done is settled mid cycle
    while (!done);
    @(posedge clk);
  endtask

  initial begin
    rst_n      = 1'b1;
    freq_we    = 1'b0;
    freq_sym   = '0;
    freq_count = '0;
    start      = 1'b0;
    lfsr_state = 32'h152c;
    repeat (4) @(posedge clk);
    rst_n <= 1'b0;
    for (int t = 0; t < NUM_TABLES; t++) begin
      load_table(t % 5);
      run_build();
    end
    repeat (2) @(posedge clk);
    $display("test passed");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    check_failed("watchdog expired before the last build finished");
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+design
design/htree_pkg.sv
design/leaf_picker.sv
design/sum_picker.sv
design/node_merger.sv
design/htree_builder.sv
verification/tb_node_mem.sv
verification/htree_tb.sv
